/* sources.f */
rasterGeomPkg.sv
drawCtrlPkg.sv
pixelIf.sv
lineRasterizer.sv
pixelBitmap.sv
lineDrawTop.sv
lineDrawTb.sv

/* Bender.yml */
package:
  name: line_draw

sources:
  # Packages first, the interface and RTL depend on them
  - rasterGeomPkg.sv
  - drawCtrlPkg.sv
  - pixelIf.sv
  - lineRasterizer.sv
  - pixelBitmap.sv
  - lineDrawTop.sv
  - target: test
    files:
      - lineDrawTb.sv

/* lineDrawTb.sv */
// Testbench for the two engine line drawing subsystem
// Traces lines on both engines, checks busy and done timing every cycle
// and compares each bitmap row with a Bresenham reference image

module lineDrawTb
	import rasterGeomPkg::*;
	import drawCtrlPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CoordBits  = DefaultCoordBits;
	localparam int GridSize   = 1 << CoordBits;
	localparam int ClkPeriod  = 40;
	localparam int TotalLines = 31;
	localparam int ImageReads = 28;
	// Trace cycles per line, then one row per cycle for each readout, plus slack
	localparam int WatchCycles =
		TotalLines * (GridSize + 10) + ImageReads * (GridSize + 4) + 100;

	logic                   clk = 1'b0;
	logic                   n_rst;
	logic [EngineCount-1:0] start;
	logic [CoordBits-1:0]   x0 [EngineCount];
	logic [CoordBits-1:0]   y0 [EngineCount];
	logic [CoordBits-1:0]   x1 [EngineCount];
	logic [CoordBits-1:0]   y1 [EngineCount];
	wire  [EngineCount-1:0] busy;
	wire  [EngineCount-1:0] done;
	logic                   clear;
	logic [CoordBits-1:0]   rowAddr;
	wire  [GridSize-1:0]    rowData;

	// Reference image, bit index is x
	logic [GridSize-1:0] model [GridSize];

	int lineStart [EngineCount];
	int lineLen   [EngineCount];
	int cyc = 0;
	int errors;
	int seed;

	// Directed lines for engine A, columns x0 y0 x1 y1
	int directed [12][4] = '{
		'{10, 10, 50, 20}, '{10, 10, 20, 50}, '{50, 10, 10, 20}, '{50, 10, 40, 50},
		'{10, 50, 50, 40}, '{10, 50, 20, 5},  '{50, 50, 5, 40},  '{50, 50, 40, 3},
		'{3, 30, 60, 30},  '{30, 60, 30, 2},  '{17, 17, 17, 17}, '{0, 0, 63, 63}
	};

	lineDrawTop uut
	(
		.clk     (clk),
		.n_rst   (n_rst),
		.startA  (start[0]),
		.x0A     (x0[0]),
		.y0A     (y0[0]),
		.x1A     (x1[0]),
		.y1A     (y1[0]),
		.busyA   (busy[0]),
		.doneA   (done[0]),
		.startB  (start[1]),
		.x0B     (x0[1]),
		.y0B     (y0[1]),
		.x1B     (x1[1]),
		.y1B     (y1[1]),
		.busyB   (busy[1]),
		.doneB   (done[1]),
		.clear   (clear),
		.rowAddr (rowAddr),
		.rowData (rowData)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	task automatic flagError(input string msg);
		errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	function automatic int randCoord();
		return $random(seed) & (GridSize - 1);
	endfunction

	function automatic int lineLength(input int ax, input int ay, input int bx, input int by);
		int dx;
		int dy;
		dx = (bx >= ax) ? bx - ax : ax - bx;
		dy = (by >= ay) ? by - ay : ay - by;
		return ((dx > dy) ? dx : dy) + 1;
	endfunction

	task automatic clearModel();
		for (int r = 0; r < GridSize; r++)
			model[r] = '0;
	endtask

	// Reference Bresenham trace, the first skip pixels are left out
	task automatic modelLine(input int ax, input int ay, input int bx, input int by,
		input int skip);
		int dx;
		int dy;
		int err;
		int e2;
		int x;
		int y;
		int k;
		bit reached;
		stepDir_t sx;
		stepDir_t sy;
		dx = (bx >= ax) ? bx - ax : ax - bx;
		dy = (by >= ay) ? by - ay : ay - by;
		sx = (bx >= ax) ? stepPos : stepNeg;
		sy = (by >= ay) ? stepPos : stepNeg;
		err = dx - dy;
		x = ax;
		y = ay;
		k = 0;
		reached = 1'b0;
		while (!reached)
		begin
			if (k >= skip)
				model[y][x] = 1'b1;
			if ((x == bx) && (y == by))
				reached = 1'b1;
			else
			begin
				e2 = 2 * err;
				if (e2 > -dy)
				begin
					err -= dy;
					x += (sx == stepPos) ? 1 : -1;
				end
				if (e2 < dx)
				begin
					err += dx;
					y += (sy == stepPos) ? 1 : -1;
				end
			end
			k++;
		end
	endtask

	// Drives one start request and records its expected timing and pixels
	task automatic issueLine(input int e, input int ax, input int ay, input int bx,
		input int by);
		x0[e] = ax;
		y0[e] = ay;
		x1[e] = bx;
		y1[e] = by;
		start[e] = 1'b1;
		lineStart[e] = cyc;
		lineLen[e] = lineLength(ax, ay, bx, by);
		modelLine(ax, ay, bx, by, 0);
	endtask

	// Drops the strobes, then waits for done on every engine in mask
	task automatic waitLines(input logic [EngineCount-1:0] mask);
		logic [EngineCount-1:0] seen;
		seen = '0;
		while ((seen & mask) != mask)
		begin
			@(negedge clk);
			start = '0;
			clear = 1'b0;
			seen = seen | done;
		end
		@(negedge clk);
	endtask

	task automatic clearImage();
		clear = 1'b1;
		@(negedge clk);
		clear = 1'b0;
		clearModel();
	endtask

	task automatic checkImage(input string tag);
		for (int r = 0; r < GridSize; r++)
		begin
			rowAddr = r;
			@(negedge clk);
			rowMatch: assert (rowData === model[r])
				else flagError($sformatf("%s: row %0d read %h, expected %h",
					tag, r, rowData, model[r]));
		end
	endtask

	// Busy covers N cycles from the second edge after start, done follows once
	always @(posedge clk)
	begin
		int rel;
		rasterState_t st;
		if (n_rst)
		begin
			for (int e = 0; e < EngineCount; e++)
			begin
				rel = cyc + 1 - lineStart[e];
				st = (e == 0) ? uut.rasterA.state : uut.rasterB.state;
				busyTiming: assert (busy[e] === (rel >= 2 && rel <= lineLen[e] + 1))
					else flagError($sformatf("engine %0d busy %b at cycle %0d of %0d, state %s",
						e, busy[e], rel - 1, lineLen[e], st.name()));
				doneTiming: assert (done[e] === (rel == lineLen[e] + 2))
					else flagError($sformatf("engine %0d done %b at cycle %0d of %0d, state %s",
						e, done[e], rel - 1, lineLen[e], st.name()));
			end
		end
		cyc <= cyc + 1;
	end

	initial
	begin
		#(WatchCycles * ClkPeriod);
		$display("Watchdog expired at %0t ns, a done pulse or row readout never arrived", $time);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		int e;
		seed = 87467;
		errors = 0;
		n_rst = 1'b0;
		start = '0;
		clear = 1'b0;
		rowAddr = '0;
		for (int i = 0; i < EngineCount; i++)
		begin
			x0[i] = '0;
			y0[i] = '0;
			x1[i] = '0;
			y1[i] = '0;
			lineStart[i] = -1000;
			lineLen[i] = 0;
		end
		clearModel();
		repeat (2) @(negedge clk);
		n_rst = 1'b1;

		checkImage("after reset");

		// All eight octants, straight lines, a single point and the full diagonal
		for (int i = 0; i < 12; i++)
		begin
			clearImage();
			issueLine(0, directed[i][0], directed[i][1], directed[i][2], directed[i][3]);
			waitLines(1);
			checkImage($sformatf("directed line %0d", i));
		end

		// Both engines started in the same cycle
		for (int i = 0; i < 4; i++)
		begin
			clearImage();
			for (e = 0; e < EngineCount; e++)
				issueLine(e, randCoord(), randCoord(), randCoord(), randCoord());
			waitLines('1);
			checkImage("parallel lines");
		end

		// A second request while busy leaves no trace
		clearImage();
		issueLine(0, 2, 60, 61, 9);
		@(negedge clk);
		start = '0;
		repeat (3) @(negedge clk);
		x0[0] = 5;
		y0[0] = 5;
		x1[0] = 5;
		y1[0] = 50;
		start[0] = 1'b1;
		waitLines(1);
		checkImage("start while busy");

		clearImage();
		checkImage("after clear");

		// Clear in the middle of a trace keeps only the later pixels
		issueLine(0, 0, 5, 63, 40);
		@(negedge clk);
		start = '0;
		repeat (20) @(negedge clk);
		clear = 1'b1;
		clearModel();
		modelLine(0, 5, 63, 40, cyc - lineStart[0]);
		waitLines(1);
		checkImage("clear during trace");

		// Lines pile up without clear
		clearImage();
		for (int i = 0; i < 8; i++)
		begin
			e = i % EngineCount;
			issueLine(e, randCoord(), randCoord(), randCoord(), randCoord());
			waitLines(1 << e);
			checkImage($sformatf("accumulated line %0d", i));
		end

		$display("Line drawing run finished with %0d errors", errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* lineDrawTop.sv */
// Two engine line drawing subsystem
// Two Bresenham engines trace lines side by side into one shared
// bitmap, which is cleared by a strobe and read back by row

module lineDrawTop
	import rasterGeomPkg::*;
	import drawCtrlPkg::*;
#(
	parameter int CoordBits = DefaultCoordBits
)
(
	input  logic                           clk,
	input  logic                           n_rst,

	// Engine A
	input  logic                           startA,
	input  logic [CoordBits-1:0]           x0A,
	input  logic [CoordBits-1:0]           y0A,
	input  logic [CoordBits-1:0]           x1A,
	input  logic [CoordBits-1:0]           y1A,
	output logic                           busyA,
	output logic                           doneA,

	// Engine B
	input  logic                           startB,
	input  logic [CoordBits-1:0]           x0B,
	input  logic [CoordBits-1:0]           y0B,
	input  logic [CoordBits-1:0]           x1B,
	input  logic [CoordBits-1:0]           y1B,
	output logic                           busyB,
	output logic                           doneB,

	// Bitmap access
	input  logic                           clear,
	input  logic [CoordBits-1:0]           rowAddr,
	output logic [gridEdge(CoordBits)-1:0] rowData
);

	// The bitmap has exactly two plot ports
	if (EngineCount != 2)
	begin : engineCountCheck
		$error("bitmap merges two engines, EngineCount is %0d", EngineCount);
	end

	pixelIf #(.CoordBits(CoordBits)) pixA ();
	pixelIf #(.CoordBits(CoordBits)) pixB ();

	lineRasterizer #(.CoordBits(CoordBits)) rasterA
	(
		.clk   (clk),
		.n_rst (n_rst),
		.start (startA),
		.x0    (x0A),
		.y0    (y0A),
		.x1    (x1A),
		.y1    (y1A),
		.pix   (pixA.source)
	);

	lineRasterizer #(.CoordBits(CoordBits)) rasterB
	(
		.clk   (clk),
		.n_rst (n_rst),
		.start (startB),
		.x0    (x0B),
		.y0    (y0B),
		.x1    (x1B),
		.y1    (y1B),
		.pix   (pixB.source)
	);

	pixelBitmap #(.CoordBits(CoordBits)) bitmap
	(
		.clk     (clk),
		.n_rst   (n_rst),
		.clear   (clear),
		.rowAddr (rowAddr),
		.portA   (pixA.sink),
		.portB   (pixB.sink),
		.rowData (rowData)
	);

	// Engine status straight from the pixel streams
	assign busyA = pixA.busy;
	assign doneA = pixA.done;
	assign busyB = pixB.busy;
	assign doneB = pixB.done;

endmodule

/* pixelBitmap.sv */
// Monochrome line bitmap
// Merges the plot streams of two engines into one square image,
// clears it on a strobe and reads it back one registered row at a time

module pixelBitmap
	import rasterGeomPkg::*;
#(
	parameter int CoordBits = DefaultCoordBits
)
(
	input  logic                           clk,
	input  logic                           n_rst,
	input  logic                           clear,
	input  logic [CoordBits-1:0]           rowAddr,
	pixelIf.sink                           portA,
	pixelIf.sink                           portB,
	output logic [gridEdge(CoordBits)-1:0] rowData
);

	localparam int GridEdge = gridEdge(CoordBits);

	// One register per row, bit index is the x coordinate
	logic [GridEdge-1:0] image     [GridEdge];
	logic [GridEdge-1:0] nextImage [GridEdge];

	logic [GridEdge-1:0] colA;
	logic [GridEdge-1:0] colB;

	// Column decode of each plot position
	assign colA = {{(GridEdge-1){1'b0}}, 1'b1} << portA.x;
	assign colB = {{(GridEdge-1){1'b0}}, 1'b1} << portB.x;

	always_comb
	begin
		for (int r = 0; r < GridEdge; r++)
		begin
			nextImage[r] = image[r];
			// Both engines may hit the same row in one cycle
			if (portA.plot && (portA.y == r))
				nextImage[r] = nextImage[r] | colA;
			if (portB.plot && (portB.y == r))
				nextImage[r] = nextImage[r] | colB;
			// Clear beats any plot of the same cycle
			if (clear)
				nextImage[r] = '0;
		end
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
		begin
			image   <= '{default: '0};
			rowData <= '0;
		end
		else
		begin
			image   <= nextImage;
			// Readout already includes the writes of this edge
			rowData <= nextImage[rowAddr];
		end
	end

	rowAddrKnown: assert property (@(posedge clk) disable iff (!n_rst)
		!$isunknown(rowAddr))
		else $error("row address has unknown bits");

endmodule

/* lineRasterizer.sv */
// Bresenham line engine
// Captures two endpoints on start and traces the line between them,
// one pixel plot per clock, then pulses done for one cycle

module lineRasterizer
	import rasterGeomPkg::*;
	import drawCtrlPkg::*;
#(
	parameter int CoordBits = DefaultCoordBits
)
(
	input  logic                 clk,
	input  logic                 n_rst,
	input  logic                 start,
	input  logic [CoordBits-1:0] x0,
	input  logic [CoordBits-1:0] y0,
	input  logic [CoordBits-1:0] x1,
	input  logic [CoordBits-1:0] y1,
	pixelIf.source               pix
);

	// Two extra bits hold the sign and the overshoot of the error past one delta
	localparam int ErrBits = CoordBits + 2;

	rasterState_t state;

	logic [CoordBits-1:0] curX;
	logic [CoordBits-1:0] curY;
	logic [CoordBits-1:0] endX;
	logic [CoordBits-1:0] endY;
	logic [CoordBits-1:0] dx;
	logic [CoordBits-1:0] dy;
	logic [CoordBits-1:0] absDx;
	logic [CoordBits-1:0] absDy;
	stepDir_t             sx;
	stepDir_t             sy;

	logic signed [ErrBits-1:0] err;
	logic signed [ErrBits-1:0] errNext;
	logic signed [ErrBits:0]   err2;
	logic signed [ErrBits-1:0] dxS;
	logic signed [ErrBits-1:0] dyS;

	logic accept;
	logic atEnd;
	logic stepX;
	logic stepY;

	// Deltas of the incoming endpoint pair
	assign absDx = (x1 >= x0) ? x1 - x0 : x0 - x1;
	assign absDy = (y1 >= y0) ? y1 - y0 : y0 - y1;

	assign accept = (state == rsIdle) && start;
	assign atEnd  = (curX == endX) && (curY == endY);

	// Standard Bresenham decision on twice the error
	// Twice the error needs one bit more than the error register
	assign dxS   = $signed({2'b00, dx});
	assign dyS   = $signed({2'b00, dy});
	assign err2  = $signed({err, 1'b0});
	assign stepX = err2 > -dyS;
	assign stepY = err2 < dxS;

	always_comb
	begin
		errNext = err;
		if (stepX)
			errNext = errNext - dyS;
		if (stepY)
			errNext = errNext + dxS;
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (!n_rst)
			state <= rsIdle;
		else
		begin
			case (state)
				rsIdle:
				begin
					if (start)
						state <= rsTrace;
				end
				rsTrace:
				begin
					if (atEnd)
						state <= rsFinish;
				end
				rsFinish:
					state <= rsIdle;
				default:
					state <= rsIdle;
			endcase
		end
	end

	// Line datapath, loaded on an accepted start
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			curX <= x0;
			curY <= y0;
			endX <= x1;
			endY <= y1;
			dx   <= absDx;
			dy   <= absDy;
			sx   <= stepToward(int'(x0), int'(x1));
			sy   <= stepToward(int'(y0), int'(y1));
			err  <= $signed({2'b00, absDx}) - $signed({2'b00, absDy});
		end
		else if ((state == rsTrace) && !atEnd)
		begin
			// Diagonal moves take both branches in the same cycle
			if (stepX)
				curX <= (sx == stepPos) ? curX + 1'b1 : curX - 1'b1;
			if (stepY)
				curY <= (sy == stepPos) ? curY + 1'b1 : curY - 1'b1;
			err <= errNext;
		end
	end

	// Every trace cycle plots the current point
	assign pix.plot = (state == rsTrace);
	assign pix.busy = (state == rsTrace);
	assign pix.done = (state == rsFinish);
	assign pix.x    = curX;
	assign pix.y    = curY;

	// True when two coordinates are at most one apart, without wrapping
	function automatic logic axisStepOk(input logic [CoordBits-1:0] a,
		input logic [CoordBits-1:0] b);
		logic [CoordBits:0] wa;
		logic [CoordBits:0] wb;
		wa = a;
		wb = b;
		return (wa == wb) || (wa + 1'b1 == wb) || (wb + 1'b1 == wa);
	endfunction

	// The traced point never passes the endpoint on either axis
	noOvershoot: assert property (@(posedge clk) disable iff (!n_rst)
		pix.plot |->
			((sx == stepPos) ? (curX <= endX) : (curX >= endX)) &&
			((sy == stepPos) ? (curY <= endY) : (curY >= endY)))
		else $error("pixel (%0d,%0d) passed endpoint (%0d,%0d) in state %s",
			pix.x, pix.y, endX, endY, state.name());

	// Consecutive pixels of a line touch each other
	unitStep: assert property (@(posedge clk) disable iff (!n_rst)
		pix.plot && $past(pix.plot) |->
			axisStepOk(pix.x, $past(pix.x)) && axisStepOk(pix.y, $past(pix.y)))
		else $error("pixel jump to (%0d,%0d)", pix.x, pix.y);

endmodule

/* pixelIf.sv */
// Pixel stream of one line engine
// One plot strobe per pixel with its position, plus the engine's
// busy level and done pulse

interface pixelIf
	import rasterGeomPkg::*;
#(
	parameter int CoordBits = DefaultCoordBits
)
();

	logic                 plot;
	logic [CoordBits-1:0] x;
	logic [CoordBits-1:0] y;
	logic                 busy;
	logic                 done;

	// Engine side
	modport source
	(
		output plot,
		output x,
		output y,
		output busy,
		output done
	);

	// Bitmap side, position only matters while plot is high
	modport sink
	(
		input plot,
		input x,
		input y
	);

endinterface

/* drawCtrlPkg.sv */
// Line engine control definitions
// Engine count of the subsystem and the engine FSM encoding

package drawCtrlPkg;

	// Engines sharing the one bitmap
	localparam int EngineCount = 2;

	// Engine FSM
	// rsIdle waits for start, rsTrace plots one pixel per clock,
	// rsFinish is the single done cycle
	typedef enum logic [1:0]
	{
		rsIdle   = 2'd0,
		rsTrace  = 2'd1,
		rsFinish = 2'd2
	} rasterState_t;

endpackage

/* rasterGeomPkg.sv */
// Raster grid geometry
// Coordinate width default, axis step direction and grid edge helper,
// shared by the line engines, the bitmap and the testbench model

package rasterGeomPkg;

	// Default width of one coordinate, giving a 64 by 64 grid
	localparam int DefaultCoordBits = 6;

	// Direction of one step along a single axis
	typedef enum logic
	{
		stepNeg = 1'b0,
		stepPos = 1'b1
	} stepDir_t;

	// Number of pixels along one edge of the square grid
	function automatic int gridEdge(input int coordBits);
		return 1 << coordBits;
	endfunction

	// Direction from a start coordinate toward an end coordinate
	// (equal coordinates never step, so the choice there is free)
	function automatic stepDir_t stepToward(input int fromCoord, input int toCoord);
		stepDir_t dir;
		if (toCoord >= fromCoord)
			dir = stepPos;
		else
			dir = stepNeg;
		return dir;
	endfunction

endpackage
